// File: include/bpu_consts.svh
`ifndef BPU_CONSTS_SVH
`define BPU_CONSTS_SVH

// BHT index width, 64 counters
`define BPU_BHT_IDX_W 6

// BTB index width, 32 entries
`define BPU_BTB_IDX_W 5

// Instructions are word aligned, so indexing starts above bit 1
`define BPU_PC_LSB 2

// Run length of the regression
`define BPU_PHASE_CYCLES 400
`define BPU_PHASE_COUNT 6
`define BPU_WATCHDOG_SLACK 100

`endif

// File: hdl/isa_pkg.sv
package isa_pkg;

    // One fetched instruction word
    typedef logic [31:0] inst_t;

    // Major opcode field
    typedef logic [5:0] opcode_t;

    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;

    // Branch opcodes decoded by the front end
    // beqz and bnez sit below this range and are left to the backend
    localparam opcode_t OPC_BCEQZ = 6'b010010;  // bceqz and bcnez share it
    localparam opcode_t OPC_JIRL  = 6'b010011;
    localparam opcode_t OPC_B     = 6'b010100;
    localparam opcode_t OPC_BL    = 6'b010101;
    localparam opcode_t OPC_BEQ   = 6'b010110;
    localparam opcode_t OPC_BNE   = 6'b010111;
    localparam opcode_t OPC_BLT   = 6'b011000;
    localparam opcode_t OPC_BGE   = 6'b011001;
    localparam opcode_t OPC_BLTU  = 6'b011010;
    localparam opcode_t OPC_BGEU  = 6'b011011;

    localparam opcode_t OPC_BR_FIRST = OPC_BCEQZ;
    localparam opcode_t OPC_BR_LAST  = OPC_BGEU;

    function automatic opcode_t opcode_of(input inst_t inst);
        return inst[OPC_MSB:OPC_LSB];
    endfunction

endpackage

// File: hdl/bpu_types_pkg.sv
`include "bpu_consts.svh"

package bpu_types_pkg;

    // PC or branch target
    typedef logic [31:0] addr_t;

    // Two-bit saturating counter, upper bit is the prediction
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_MIN   = 2'd0;
    localparam ctr_t CTR_MAX   = 2'd3;
    localparam ctr_t CTR_RESET = 2'd1;  // weakly not taken

    // BTB tag covers the PC bits above the index
    localparam int BTB_TAG_W = 32 - `BPU_PC_LSB - `BPU_BTB_IDX_W;

    typedef logic [BTB_TAG_W-1:0] btb_tag_t;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        addr_t    target;
    } btb_entry_t;

    // One bit per issue slot, slot 0 in bit 0
    typedef logic [1:0] slot_mask_t;

    localparam slot_mask_t KEEP_SLOT0 = 2'b01;
    localparam slot_mask_t KEEP_BOTH  = 2'b11;

endpackage

// File: hdl/bpu_update_if.sv
`timescale 1ns/1ps

// Branch resolution from the backend, one update per strobe
interface bpu_update_if;

    logic                 upd_en;
    bpu_types_pkg::addr_t upd_pc;
    logic                 upd_taken;
    bpu_types_pkg::addr_t upd_target;

    modport src (
        output upd_en,
        output upd_pc,
        output upd_taken,
        output upd_target
    );

    // Read by both prediction tables
    modport sink (
        input upd_en,
        input upd_pc,
        input upd_taken,
        input upd_target
    );

endinterface

// File: hdl/bht_d.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bht_d #(
    parameter int IDX_W = `BPU_BHT_IDX_W
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  bpu_types_pkg::addr_t [1:0] pc,
    bpu_update_if.sink                 upd,
    output logic [1:0]                 taken
);

    localparam int DEPTH = 1 << IDX_W;

    bpu_types_pkg::ctr_t ctr_q [DEPTH];

    logic [IDX_W-1:0]    rd_idx [2];
    logic [IDX_W-1:0]    wr_idx;
    bpu_types_pkg::ctr_t ctr_old;
    bpu_types_pkg::ctr_t ctr_new;

    for (genvar s = 0; s < 2; s++) begin : g_rd_idx
        assign rd_idx[s] = pc[s][`BPU_PC_LSB +: IDX_W];
    end

    assign wr_idx = upd.upd_pc[`BPU_PC_LSB +: IDX_W];

    ////////////////////
    // Counter training
    always_comb begin
        ctr_old = ctr_q[wr_idx];
        ctr_new = ctr_old;
        if (upd.upd_taken) begin
            if (ctr_old != bpu_types_pkg::CTR_MAX) begin
                ctr_new = ctr_old + 2'd1;
            end
        end else if (ctr_old != bpu_types_pkg::CTR_MIN) begin
            ctr_new = ctr_old - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= bpu_types_pkg::CTR_RESET;
            end
        end else if (upd.upd_en) begin
            ctr_q[wr_idx] <= ctr_new;
        end
    end

    ////////////////////
    // Lookup, sees the table before this edge's update
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            taken <= '0;
        end else begin
            for (int s = 0; s < 2; s++) begin
                taken[s] <= ctr_q[rd_idx[s]][1];
            end
        end
    end

endmodule

// File: hdl/btb_d.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"

module btb_d #(
    parameter int IDX_W = `BPU_BTB_IDX_W
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  bpu_types_pkg::addr_t [1:0] pc,
    bpu_update_if.sink                 upd,
    output bpu_types_pkg::addr_t [1:0] target,
    output logic [1:0]                 hit
);

    localparam int DEPTH = 1 << IDX_W;
    localparam int TAG_W = bpu_types_pkg::BTB_TAG_W;

    // Entry storage
    logic [DEPTH-1:0]        valid_q;
    bpu_types_pkg::btb_tag_t tag_mem [DEPTH];
    bpu_types_pkg::addr_t    tgt_mem [DEPTH];

    logic [IDX_W-1:0]          rd_idx [2];
    bpu_types_pkg::btb_entry_t rd_ent [2];
    logic [1:0]                rd_hit;

    logic [IDX_W-1:0]          wr_idx;
    logic                      wr_en;

    ////////////////////
    // Read side
    for (genvar s = 0; s < 2; s++) begin : g_rd
        assign rd_idx[s]        = pc[s][`BPU_PC_LSB +: IDX_W];
        assign rd_ent[s].valid  = valid_q[rd_idx[s]];
        assign rd_ent[s].tag    = tag_mem[rd_idx[s]];
        assign rd_ent[s].target = tgt_mem[rd_idx[s]];
        assign rd_hit[s] = rd_ent[s].valid && (rd_ent[s].tag == pc[s][31 -: TAG_W]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit <= '0;
        end else begin
            hit <= rd_hit;
        end
    end

    // Stored target of each slot's entry
    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            target[s] <= rd_ent[s].target;
        end
    end

    ////////////////////
    // Install on taken updates only
    assign wr_en  = upd.upd_en && upd.upd_taken;
    assign wr_idx = upd.upd_pc[`BPU_PC_LSB +: IDX_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx] <= upd.upd_pc[31 -: TAG_W];
            tgt_mem[wr_idx] <= upd.upd_target;
        end
    end

endmodule

// File: hdl/bpu_d.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bpu_d (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       stall,
    input  bpu_types_pkg::addr_t [1:0] pc,
    input  isa_pkg::inst_t [1:0]       inst,
    input  logic [1:0]                 inst_en,
    bpu_update_if.sink                 upd,
    output bpu_types_pkg::slot_mask_t  is_branch,
    output bpu_types_pkg::slot_mask_t  pre_taken,
    output bpu_types_pkg::addr_t       pre_target,
    output logic                       taken_sure,
    output bpu_types_pkg::slot_mask_t  fetch_inst_en
);

    isa_pkg::opcode_t                opc [2];
    bpu_types_pkg::slot_mask_t       br_dec;
    bpu_types_pkg::slot_mask_t       en_q;
    bpu_types_pkg::addr_t [1:0]      btb_target;
    bpu_types_pkg::slot_mask_t       btb_hit;
    bpu_types_pkg::slot_mask_t       qualify;

    ////////////////////
    // Branch decode
    for (genvar s = 0; s < 2; s++) begin : g_dec
        assign opc[s]    = isa_pkg::opcode_of(inst[s]);
        assign br_dec[s] = !stall
                        && (opc[s] >= isa_pkg::OPC_BR_FIRST)
                        && (opc[s] <= isa_pkg::OPC_BR_LAST);
    end

    // Aligned with the table lookups
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            is_branch <= '0;
            en_q      <= '0;
        end else begin
            is_branch <= br_dec;
            en_q      <= inst_en;
        end
    end

    ////////////////////
    // Tables
    bht_d #(
        .IDX_W (`BPU_BHT_IDX_W)
    ) bht_i (
        .clk    (clk),
        .arst_n (arst_n),
        .pc     (pc),
        .upd    (upd),
        .taken  (pre_taken)
    );

    btb_d #(
        .IDX_W (`BPU_BTB_IDX_W)
    ) btb_i (
        .clk    (clk),
        .arst_n (arst_n),
        .pc     (pc),
        .upd    (upd),
        .target (btb_target),
        .hit    (btb_hit)
    );

    ////////////////////
    // Redirect selection, slot 0 first
    assign qualify = is_branch & pre_taken & en_q & btb_hit;

    always_comb begin
        if (qualify[0]) begin
            // Drop slot 1, it follows a taken branch
            fetch_inst_en = bpu_types_pkg::KEEP_SLOT0;
            pre_target    = btb_target[0];
            taken_sure    = 1'b1;
        end else if (qualify[1]) begin
            fetch_inst_en = bpu_types_pkg::KEEP_BOTH;
            pre_target    = btb_target[1];
            taken_sure    = 1'b1;
        end else begin
            fetch_inst_en = bpu_types_pkg::KEEP_BOTH;
            pre_target    = '0;
            taken_sure    = 1'b0;
        end
    end

endmodule

// File: hdl/bpu_top.sv
`timescale 1ns/1ps

module bpu_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 stall,
    input  bpu_types_pkg::addr_t pc0,
    input  bpu_types_pkg::addr_t pc1,
    input  isa_pkg::inst_t       inst0,
    input  isa_pkg::inst_t       inst1,
    input  logic                 inst_en0,
    input  logic                 inst_en1,
    input  logic                 upd_en,
    input  bpu_types_pkg::addr_t upd_pc,
    input  logic                 upd_taken,
    input  bpu_types_pkg::addr_t upd_target,
    output logic [1:0]           is_branch,
    output logic [1:0]           pre_taken,
    output bpu_types_pkg::addr_t pre_target,
    output logic                 taken_sure,
    output logic [1:0]           fetch_inst_en
);

    bpu_types_pkg::addr_t [1:0] pc_pair;
    isa_pkg::inst_t [1:0]       inst_pair;

    bpu_update_if upd_if ();

    // Update port bundled for the tables
    assign upd_if.upd_en     = upd_en;
    assign upd_if.upd_pc     = upd_pc;
    assign upd_if.upd_taken  = upd_taken;
    assign upd_if.upd_target = upd_target;

    // Slot 0 in index 0
    assign pc_pair   = {pc1, pc0};
    assign inst_pair = {inst1, inst0};

    bpu_d bpu_d_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .pc            (pc_pair),
        .inst          (inst_pair),
        .inst_en       ({inst_en1, inst_en0}),
        .upd           (upd_if),
        .is_branch     (is_branch),
        .pre_taken     (pre_taken),
        .pre_target    (pre_target),
        .taken_sure    (taken_sure),
        .fetch_inst_en (fetch_inst_en)
    );

endmodule

// File: sim/bpu_checker.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"

module bpu_checker (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 stall,
    input  bpu_types_pkg::addr_t pc0,
    input  bpu_types_pkg::addr_t pc1,
    input  isa_pkg::inst_t       inst0,
    input  isa_pkg::inst_t       inst1,
    input  logic                 inst_en0,
    input  logic                 inst_en1,
    input  logic                 upd_en,
    input  bpu_types_pkg::addr_t upd_pc,
    input  logic                 upd_taken,
    input  bpu_types_pkg::addr_t upd_target,
    input  logic [1:0]           is_branch,
    input  logic [1:0]           pre_taken,
    input  bpu_types_pkg::addr_t pre_target,
    input  logic                 taken_sure,
    input  logic [1:0]           fetch_inst_en,
    input  int                   phase,
    output int                   err_cnt,
    output int                   chk_cnt
);

    localparam int BHT_N = 1 << `BPU_BHT_IDX_W;
    localparam int BTB_N = 1 << `BPU_BTB_IDX_W;
    localparam int TAG_W = 32 - `BPU_PC_LSB - `BPU_BTB_IDX_W;
    localparam logic [5:0] BR_FIRST = 6'b010010;
    localparam logic [5:0] BR_LAST  = 6'b011011;

    // Reference tables
    logic [1:0]       bht_m   [BHT_N];
    logic             btb_v   [BTB_N];
    logic [TAG_W-1:0] btb_tag [BTB_N];
    logic [31:0]      btb_tgt [BTB_N];

    // Expected outputs for the pair sampled at the last edge
    logic [1:0]  exp_isb;
    logic [1:0]  exp_pt;
    logic [31:0] exp_tgt;
    logic        exp_sure;
    logic [1:0]  exp_fen;
    int          exp_phase;
    logic        armed;

    function automatic string phase_name(input int p);
        case (p)
            0: return "reset_values";
            1: return "opcode_decode";
            2: return "bht_training";
            3: return "btb_hits";
            4: return "slot_priority";
            default: return "mixed_random";
        endcase
    endfunction

    task automatic reset_model();
        for (int i = 0; i < BHT_N; i++) begin
            bht_m[i] = 2'd1;
        end
        for (int i = 0; i < BTB_N; i++) begin
            btb_v[i] = 1'b0;
        end
        exp_isb  = 2'b00;
        exp_pt   = 2'b00;
        exp_tgt  = '0;
        exp_sure = 1'b0;
        exp_fen  = 2'b11;
    endtask

    ////////////////////
    // Lookup against the tables as they were before this edge
    task automatic predict();
        logic [31:0] pc_s [2];
        logic [5:0]  opc_s [2];
        logic [31:0] tgt_s [2];
        logic [1:0]  hit_s;
        logic [1:0]  qual;
        int          bi;
        pc_s[0]  = pc0;
        pc_s[1]  = pc1;
        opc_s[0] = inst0[31:26];
        opc_s[1] = inst1[31:26];
        for (int s = 0; s < 2; s++) begin
            bi         = pc_s[s][`BPU_PC_LSB +: `BPU_BTB_IDX_W];
            exp_isb[s] = !stall && (opc_s[s] >= BR_FIRST) && (opc_s[s] <= BR_LAST);
            exp_pt[s]  = bht_m[pc_s[s][`BPU_PC_LSB +: `BPU_BHT_IDX_W]][1];
            hit_s[s]   = btb_v[bi] && (btb_tag[bi] == pc_s[s][31 -: TAG_W]);
            tgt_s[s]   = btb_tgt[bi];
        end
        qual = exp_isb & exp_pt & {inst_en1, inst_en0} & hit_s;
        exp_sure = qual[0] || qual[1];
        exp_fen  = qual[0] ? 2'b01 : 2'b11;
        exp_tgt  = qual[0] ? tgt_s[0] : (qual[1] ? tgt_s[1] : 32'h0);
    endtask

    task automatic train();
        int hi;
        int bi;
        hi = upd_pc[`BPU_PC_LSB +: `BPU_BHT_IDX_W];
        bi = upd_pc[`BPU_PC_LSB +: `BPU_BTB_IDX_W];
        if (upd_taken && bht_m[hi] != 2'd3) begin
            bht_m[hi] = bht_m[hi] + 2'd1;
        end else if (!upd_taken && bht_m[hi] != 2'd0) begin
            bht_m[hi] = bht_m[hi] - 2'd1;
        end
        // Not-taken branches never install
        if (upd_taken) begin
            btb_v[bi]   = 1'b1;
            btb_tag[bi] = upd_pc[31 -: TAG_W];
            btb_tgt[bi] = upd_target;
        end
    endtask

    task automatic compare(input string field, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            err_cnt++;
            $display("[FAIL] %s %s: expected %0h, actual %0h",
                     phase_name(exp_phase), field, exp_v, act_v);
        end
    endtask

    initial begin
        err_cnt = 0;
        chk_cnt = 0;
        armed   = 1'b0;
        reset_model();
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            reset_model();
        end else begin
            predict();
            if (upd_en) begin
                train();
            end
        end
        exp_phase = phase;
        armed     = 1'b1;
    end

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (armed) begin
            chk_cnt++;
            compare("is_branch", exp_isb, is_branch);
            compare("pre_taken", exp_pt, pre_taken);
            compare("pre_target", exp_tgt, pre_target);
            compare("taken_sure", exp_sure, taken_sure);
            compare("fetch_inst_en", exp_fen, fetch_inst_en);
        end
    end

endmodule

// File: sim/tb_bpu.sv
`timescale 1ns/1ps
`include "bpu_consts.svh"

module tb_bpu;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int RUN_CYCLES   = `BPU_PHASE_COUNT * `BPU_PHASE_CYCLES + `BPU_WATCHDOG_SLACK;

    logic                 clk;
    logic                 arst_n;
    logic                 stall;
    bpu_types_pkg::addr_t pc0;
    bpu_types_pkg::addr_t pc1;
    isa_pkg::inst_t       inst0;
    isa_pkg::inst_t       inst1;
    logic                 inst_en0;
    logic                 inst_en1;
    logic                 upd_en;
    bpu_types_pkg::addr_t upd_pc;
    logic                 upd_taken;
    bpu_types_pkg::addr_t upd_target;
    logic [1:0]           is_branch;
    logic [1:0]           pre_taken;
    bpu_types_pkg::addr_t pre_target;
    logic                 taken_sure;
    logic [1:0]           fetch_inst_en;
    int                   phase;
    int                   err_cnt;
    int                   chk_cnt;
    integer               seed;

    bpu_top dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (stall),
        .pc0           (pc0),
        .pc1           (pc1),
        .inst0         (inst0),
        .inst1         (inst1),
        .inst_en0      (inst_en0),
        .inst_en1      (inst_en1),
        .upd_en        (upd_en),
        .upd_pc        (upd_pc),
        .upd_taken     (upd_taken),
        .upd_target    (upd_target),
        .is_branch     (is_branch),
        .pre_taken     (pre_taken),
        .pre_target    (pre_target),
        .taken_sure    (taken_sure),
        .fetch_inst_en (fetch_inst_en)
    );

    bpu_checker checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", RUN_CYCLES);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    // Upper four PCs alias the lower four in the BTB, not in the BHT
    function automatic bpu_types_pkg::addr_t pool_pc(input logic [31:0] r);
        return 32'h1c00_0000 | {24'd0, r[2], 3'd0, r[1:0], 2'd0};
    endfunction

    function automatic isa_pkg::inst_t branch_inst();
        logic [31:0] r;
        logic [5:0]  opc;
        r   = next_rand();
        opc = 6'b010010 + r[31:26] % 10;
        return {opc, r[25:0]};
    endfunction

    function automatic isa_pkg::inst_t mixed_inst();
        logic [31:0] r;
        r = next_rand();
        return r[0] ? branch_inst() : next_rand();
    endfunction

    ////////////////////
    // One input pair and one update per call
    task automatic drive_cycle(input int ph, input int cyc);
        logic [31:0]          r;
        bpu_types_pkg::addr_t p0;
        bpu_types_pkg::addr_t p1;
        bpu_types_pkg::addr_t up;
        r  = next_rand();
        p0 = pool_pc(next_rand());
        p1 = pool_pc(next_rand());
        up = pool_pc(next_rand());
        stall      <= 1'b0;
        inst_en0   <= 1'b1;
        inst_en1   <= 1'b1;
        inst0      <= branch_inst();
        inst1      <= branch_inst();
        pc0        <= p0;
        pc1        <= p1;
        upd_en     <= 1'b0;
        upd_pc     <= r[5] ? p0 : up;
        upd_taken  <= r[4];
        upd_target <= next_rand() & 32'hffff_fffc;
        case (ph)
            0: begin
                inst_en0 <= 1'b0;
                inst_en1 <= 1'b0;
                inst0    <= '0;
                inst1    <= '0;
            end
            1: begin
                inst0    <= mixed_inst();
                inst1    <= mixed_inst();
                stall    <= r[0];
                inst_en0 <= r[1];
                inst_en1 <= r[2];
            end
            // Mostly taken first, then mostly not taken
            2: begin
                upd_en    <= r[0] | r[1];
                upd_taken <= (cyc < `BPU_PHASE_CYCLES / 2) ? (r[3:2] != 0) : (r[3:2] == 0);
            end
            3: upd_en <= r[0];
            4: begin
                inst_en0  <= r[1] | r[2];
                inst_en1  <= r[3] | r[6];
                upd_en    <= 1'b1;
                upd_taken <= r[8:7] != 0;
            end
            default: begin
                inst0    <= mixed_inst();
                inst1    <= mixed_inst();
                stall    <= r[0];
                inst_en0 <= r[1];
                inst_en1 <= r[2];
                upd_en   <= r[3];
                if (r[9]) pc1 <= next_rand();
            end
        endcase
    endtask

    initial begin
        seed       = 32'h5d19_dc80;
        phase      = 0;
        arst_n     = 1'b0;
        stall      = 1'b0;
        pc0        = '0;
        pc1        = '0;
        inst0      = '0;
        inst1      = '0;
        inst_en0   = 1'b0;
        inst_en1   = 1'b0;
        upd_en     = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        upd_target = '0;
        for (int ph = 0; ph < `BPU_PHASE_COUNT; ph++) begin
            for (int c = 0; c < `BPU_PHASE_CYCLES; c++) begin
                @(posedge clk);
                if (ph == 0 && c == RESET_CYCLES - 1) arst_n <= 1'b1;
                phase <= ph;
                drive_cycle(ph, c);
            end
        end
        repeat (3) @(posedge clk);
        $display("Checked %0d cycles, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
hdl/isa_pkg.sv
hdl/bpu_types_pkg.sv
hdl/bpu_update_if.sv
hdl/bht_d.sv
hdl/btb_d.sv
hdl/bpu_d.sv
hdl/bpu_top.sv
sim/bpu_checker.sv
sim/tb_bpu.sv

// File: Bender.yml
package:
  name: bpu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/isa_pkg.sv
      - hdl/bpu_types_pkg.sv
      - hdl/bpu_update_if.sv
      - hdl/bht_d.sv
      - hdl/btb_d.sv
      - hdl/bpu_d.sv
      - hdl/bpu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/bpu_checker.sv
      - sim/tb_bpu.sv
